// ==== include/tetris_consts.svh ====
`ifndef TETRIS_CONSTS_SVH
`define TETRIS_CONSTS_SVH

// --------------------------------------------------
// Board geometry
// --------------------------------------------------
`define BOARD_COLS   6
`define VIS_ROWS     12
`define ALL_ROWS     16    // Visible rows plus four overflow rows

`define ROUND_PIECES 16    // Round ends here at the latest

// --------------------------------------------------
// Field widths
// --------------------------------------------------
`define SHAPE_W      3
`define ROW_IDX_W    4
`define COL_IDX_W    3
`define SCORE_W      4

// Shape codes as carried on piece_i
`define SHAPE_O      3'd0  // 2x2 square
`define SHAPE_I_VERT 3'd1
`define SHAPE_I_HORZ 3'd2
`define SHAPE_J_DOWN 3'd3  // Foot on the left, stem hangs down on the right
`define SHAPE_L_FLAT 3'd4
`define SHAPE_L_UP   3'd5
`define SHAPE_S_VERT 3'd6
`define SHAPE_Z_FLAT 3'd7

`endif

// ==== hw/tetris_pkg.sv ====
`include "tetris_consts.svh"

package tetris_pkg;

	// --------------------------------------------------
	// Board words
	// --------------------------------------------------

	// One row, bit n is column n
	typedef logic [`BOARD_COLS-1:0] row_t;

	// Row 11 sits in the top bits of the flat view
	typedef union packed {
		row_t [`VIS_ROWS-1:0]                rows;
		logic [`VIS_ROWS*`BOARD_COLS-1:0]    flat;
	} board_vis_u;

	// --------------------------------------------------
	// Piece traffic
	// --------------------------------------------------
	typedef struct packed {
		logic [`SHAPE_W-1:0]   shape;
		logic [`COL_IDX_W-1:0] col;    // Leftmost column of the piece
	} piece_req_t;

	typedef struct packed {
		logic [`ROW_IDX_W-1:0] row;    // Row 0 is the floor
		logic [`COL_IDX_W-1:0] col;
	} cell_t;

	// Landing cells of one piece, order is shape specific
	typedef struct packed {
		cell_t [3:0] cells;
	} drop_plan_t;

endpackage

// ==== hw/drop_planner.sv ====
`timescale 1ns/1ps
`include "tetris_consts.svh"

module drop_planner (
	input  tetris_pkg::piece_req_t piece_i,
	input  tetris_pkg::board_vis_u board_i,
	output tetris_pkg::drop_plan_t plan_o
);

	logic [`ROW_IDX_W-1:0] col_h [`BOARD_COLS];  // One above the top filled cell
	logic [`ROW_IDX_W-1:0] near_h [4];           // Heights under the piece, left first
	logic [`ROW_IDX_W-1:0] cand [4];             // Height plus bottom offset
	logic signed [2:0]     dy [4];               // Cell row relative to the landing row
	logic [1:0]            dx [4];
	logic [`ROW_IDX_W-1:0] land_row;
	logic [`COL_IDX_W:0]   right_col;

	// Column heights from the visible rows
	always_comb begin
		for (int c = 0; c < `BOARD_COLS; c++) begin
			col_h[c] = '0;
			for (int r = 0; r < `VIS_ROWS; r++) begin
				if (board_i.rows[r][c])
					col_h[c] = `ROW_IDX_W'(r + 1);
			end
		end
	end

	always_comb begin
		for (int k = 0; k < 4; k++) begin
			if (int'(piece_i.col) + k < `BOARD_COLS)
				near_h[k] = col_h[int'(piece_i.col) + k];
			else
				near_h[k] = '0;  // Past the right edge
		end
	end

	// --------------------------------------------------
	// Bottom profile and cell layout per shape
	// --------------------------------------------------
	always_comb begin
		cand = '{near_h[0], '0, '0, '0};
		dy   = '{3'sd0, 3'sd1, 3'sd0, 3'sd1};
		dx   = '{2'd0, 2'd0, 2'd1, 2'd1};
		case (piece_i.shape)
			`SHAPE_O: begin
				cand = '{near_h[0], near_h[1], '0, '0};
			end
			`SHAPE_I_VERT: begin
				dy   = '{3'sd0, 3'sd1, 3'sd2, 3'sd3};
				dx   = '{2'd0, 2'd0, 2'd0, 2'd0};
			end
			`SHAPE_I_HORZ: begin
				cand = '{near_h[0], near_h[1], near_h[2], near_h[3]};
				dy   = '{3'sd0, 3'sd0, 3'sd0, 3'sd0};
				dx   = '{2'd0, 2'd1, 2'd2, 2'd3};
			end
			`SHAPE_J_DOWN: begin
				cand = '{near_h[0], near_h[1] + 4'd2, '0, '0};
				dy   = '{3'sd0, 3'sd0, -3'sd1, -3'sd2};
				dx   = '{2'd0, 2'd1, 2'd1, 2'd1};
			end
			`SHAPE_L_FLAT: begin
				cand = '{near_h[0] + 4'd1, near_h[1], near_h[2], '0};
				dy   = '{-3'sd1, 3'sd0, 3'sd0, 3'sd0};
				dx   = '{2'd0, 2'd0, 2'd1, 2'd2};
			end
			`SHAPE_L_UP: begin
				cand = '{near_h[0], near_h[1], '0, '0};
				dy   = '{3'sd0, 3'sd0, 3'sd1, 3'sd2};
				dx   = '{2'd0, 2'd1, 2'd0, 2'd0};
			end
			`SHAPE_S_VERT: begin
				cand = '{near_h[0] + 4'd1, near_h[1] + 4'd2, '0, '0};
				dy   = '{3'sd0, -3'sd1, -3'sd1, -3'sd2};
				dx   = '{2'd0, 2'd0, 2'd1, 2'd1};
			end
			default: begin  // Z flat
				cand = '{near_h[0] + 4'd1, near_h[1] + 4'd1, near_h[2], '0};
				dy   = '{-3'sd1, -3'sd1, 3'sd0, 3'sd0};
				dx   = '{2'd0, 2'd1, 2'd1, 2'd2};
			end
		endcase
	end

	// Landing row and the rightmost column touched
	always_comb begin
		land_row  = cand[0];
		right_col = {1'b0, piece_i.col};
		for (int k = 0; k < 4; k++) begin
			if (cand[k] > land_row)
				land_row = cand[k];
			if ({1'b0, piece_i.col} + {2'b00, dx[k]} > right_col)
				right_col = {1'b0, piece_i.col} + {2'b00, dx[k]};
		end
	end

	always_comb begin
		for (int k = 0; k < 4; k++) begin
			plan_o.cells[k].row = land_row + {dy[k][2], dy[k]};
			plan_o.cells[k].col = piece_i.col + {1'b0, dx[k]};
		end
	end

	always_comb begin
		if (!$isunknown(piece_i))
			a_inside_board: assert final (right_col < `BOARD_COLS)
				else $error("drop_planner: shape %0d at col %0d sticks out",
					piece_i.shape, piece_i.col);
	end

endmodule

// ==== hw/board_store.sv ====
`timescale 1ns/1ps
`include "tetris_consts.svh"

module board_store (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   place_i,
	input  logic                   clear_i,
	input  tetris_pkg::drop_plan_t plan_i,
	output tetris_pkg::board_vis_u board_o,
	output logic                   full_row_o,
	output logic                   overflow_o
);

	tetris_pkg::row_t [`ALL_ROWS-1:0] rows_q;
	tetris_pkg::row_t [`ALL_ROWS-1:0] rows_d;
	logic [`VIS_ROWS-1:0]             full_vec;   // One bit per complete visible row
	logic [`ROW_IDX_W-1:0]            low_full;   // Lowest complete row
	logic                             cell_hit;   // Planned cell already taken

	// --------------------------------------------------
	// Row status
	// --------------------------------------------------
	always_comb begin
		for (int r = 0; r < `VIS_ROWS; r++)
			full_vec[r] = &rows_q[r];
	end

	always_comb begin
		low_full = '0;
		for (int r = `VIS_ROWS - 1; r >= 0; r--) begin
			if (full_vec[r])
				low_full = `ROW_IDX_W'(r);
		end
	end

	assign full_row_o = |full_vec;
	assign overflow_o = |rows_q[`ALL_ROWS-1:`VIS_ROWS];  // Anything in the hidden rows
	assign board_o.rows = rows_q[`VIS_ROWS-1:0];

	// --------------------------------------------------
	// Next board
	// --------------------------------------------------
	always_comb begin
		rows_d = rows_q;
		if (clear_i) begin
			rows_d = '0;
		end else if (place_i) begin
			for (int k = 0; k < 4; k++)
				rows_d[plan_i.cells[k].row][plan_i.cells[k].col] = 1'b1;
		end else if (full_row_o) begin
			// Drop everything above the removed row by one
			for (int r = 0; r < `ALL_ROWS - 1; r++) begin
				if (r >= int'(low_full))
					rows_d[r] = rows_q[r + 1];
			end
			rows_d[`ALL_ROWS-1] = '0;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rows_q <= '0;
		end else begin
			rows_q <= rows_d;
		end
	end

	// Overlap of the planned cells with the current board
	always_comb begin
		cell_hit = 1'b0;
		for (int k = 0; k < 4; k++)
			cell_hit = cell_hit | rows_q[plan_i.cells[k].row][plan_i.cells[k].col];
	end

	// --------------------------------------------------
	// Checks
	// --------------------------------------------------
	a_place_clear: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(place_i && clear_i)
	) else $error("board_store: place_i and clear_i high together");

	// Planner must land the piece on free cells of a settled board
	a_land_free: assert property (
		@(posedge clk) disable iff (!rst_n)
		place_i |-> (!cell_hit && !full_row_o && !overflow_o)
	) else $error("board_store: piece placed over occupied or unsettled board");

endmodule

// ==== hw/round_ctrl.sv ====
`timescale 1ns/1ps
`include "tetris_consts.svh"

module round_ctrl (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             in_valid_i,
	input  logic                             full_row_i,
	input  logic                             overflow_i,
	input  tetris_pkg::board_vis_u           board_i,
	output logic                             place_o,
	output logic                             clear_o,
	output logic                             score_valid_o,
	output logic                             fail_o,
	output logic                             tetris_valid_o,
	output logic [`SCORE_W-1:0]              score_o,
	output logic [`VIS_ROWS*`BOARD_COLS-1:0] tetris_o
);

	localparam logic [1:0] ST_IDLE   = 2'd0;  // Waiting for a piece
	localparam logic [1:0] ST_SETTLE = 2'd1;  // Removing full rows
	localparam logic [1:0] ST_REPORT = 2'd2;
	localparam int         CNT_W     = $clog2(`ROUND_PIECES + 1);

	logic [1:0]          state_q;
	logic [1:0]          state_d;
	logic [CNT_W-1:0]    piece_cnt_q;
	logic [`SCORE_W-1:0] score_q;
	logic                round_end;

	// --------------------------------------------------
	// FSM
	// --------------------------------------------------
	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE:   if (in_valid_i) state_d = ST_SETTLE;
			ST_SETTLE: if (!full_row_i) state_d = ST_REPORT;  // Board has settled
			ST_REPORT: state_d = ST_IDLE;
			default:   state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= ST_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	assign place_o   = in_valid_i && (state_q == ST_IDLE);
	assign round_end = overflow_i || (piece_cnt_q == CNT_W'(`ROUND_PIECES));

	// --------------------------------------------------
	// Piece and point counters
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			piece_cnt_q <= '0;
			score_q     <= '0;
		end else if (clear_o) begin
			piece_cnt_q <= '0;
			score_q     <= '0;
		end else begin
			if (place_o)
				piece_cnt_q <= piece_cnt_q + 1'b1;
			if ((state_q == ST_SETTLE) && full_row_i)
				score_q <= score_q + 1'b1;  // One point per removed row
		end
	end

	// Outputs are zero outside their valid pulse
	assign score_valid_o  = (state_q == ST_REPORT);
	assign tetris_valid_o = score_valid_o && round_end;
	assign clear_o        = tetris_valid_o;
	assign fail_o         = score_valid_o && overflow_i;
	assign score_o        = score_valid_o ? score_q : '0;
	assign tetris_o       = tetris_valid_o ? board_i.flat : '0;

	// --------------------------------------------------
	// Checks
	// --------------------------------------------------
	a_busy_piece: assert property (
		@(posedge clk) disable iff (!rst_n)
		in_valid_i |-> (state_q == ST_IDLE)
	) else $error("round_ctrl: piece arrived while busy and was dropped");

	// Round end comes with a score pulse and leaves a fresh round behind
	a_round_end: assert property (
		@(posedge clk) disable iff (!rst_n)
		tetris_valid_o |-> score_valid_o ##1 (piece_cnt_q == '0 && score_q == '0 && !overflow_i)
	) else $error("round_ctrl: round end without score pulse or clean restart");

endmodule

// ==== hw/tetris_engine.sv ====
`timescale 1ns/1ps
`include "tetris_consts.svh"

module tetris_engine (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             in_valid_i,
	input  tetris_pkg::piece_req_t           piece_i,
	output logic                             score_valid_o,
	output logic                             fail_o,
	output logic                             tetris_valid_o,
	output logic [`SCORE_W-1:0]              score_o,
	output logic [`VIS_ROWS*`BOARD_COLS-1:0] tetris_o
);

	tetris_pkg::drop_plan_t plan;    // Landing cells of the piece on piece_i
	tetris_pkg::board_vis_u board;   // Registered visible board
	logic                   place;
	logic                   clear;
	logic                   full_row;
	logic                   overflow;

	// --------------------------------------------------
	// Input side
	// --------------------------------------------------
	drop_planner u_drop_planner (
		.piece_i (piece_i),
		.board_i (board),
		.plan_o  (plan)
	);

	// --------------------------------------------------
	// Board and row removal
	// --------------------------------------------------
	board_store u_board_store (
		.clk        (clk),
		.rst_n      (rst_n),
		.place_i    (place),
		.clear_i    (clear),
		.plan_i     (plan),
		.board_o    (board),
		.full_row_o (full_row),
		.overflow_o (overflow)
	);

	// --------------------------------------------------
	// Round control and output ports
	// --------------------------------------------------
	round_ctrl u_round_ctrl (
		.clk            (clk),
		.rst_n          (rst_n),
		.in_valid_i     (in_valid_i),
		.full_row_i     (full_row),
		.overflow_i     (overflow),
		.board_i        (board),
		.place_o        (place),
		.clear_o        (clear),
		.score_valid_o  (score_valid_o),
		.fail_o         (fail_o),
		.tetris_valid_o (tetris_valid_o),
		.score_o        (score_o),
		.tetris_o       (tetris_o)
	);

endmodule

// ==== test/tb_board_model.sv ====
`timescale 1ns/1ps
`include "tetris_consts.svh"

module tb_board_model;

	logic [`BOARD_COLS-1:0] grid [`ALL_ROWS];  // Row 0 is the floor
	int                     pieces;
	int                     score;

	// Results of the last piece
	int                               exp_score;
	logic                             exp_fail;
	logic                             exp_end;
	logic [`VIS_ROWS*`BOARD_COLS-1:0] exp_board;

	// Four cells per shape as {dx, dy} nibbles, dy 0 is the shape bottom
	function automatic logic [15:0] shape_cells(input logic [2:0] shape);
		case (shape)
			`SHAPE_O:      return 16'h0145;
			`SHAPE_I_VERT: return 16'h0123;
			`SHAPE_I_HORZ: return 16'h048c;
			`SHAPE_J_DOWN: return 16'h2654;  // Left foot on top of the stem
			`SHAPE_L_FLAT: return 16'h0159;
			`SHAPE_L_UP:   return 16'h0412;
			`SHAPE_S_VERT: return 16'h1245;
			default:       return 16'h0459;
		endcase
	endfunction

	function automatic int piece_width(input logic [2:0] shape);
		logic [15:0] cl;
		int          w;
		cl = shape_cells(shape);
		w  = 0;
		for (int k = 0; k < 4; k++) begin
			if (int'(cl[k*4+2 +: 2]) + 1 > w)
				w = int'(cl[k*4+2 +: 2]) + 1;
		end
		return w;
	endfunction

	task automatic clear_board();
		for (int r = 0; r < `ALL_ROWS; r++)
			grid[r] = '0;
		pieces = 0;
		score  = 0;
	endtask

	task automatic apply_piece(input logic [2:0] shape, input logic [2:0] col);
		int          h [`BOARD_COLS];
		logic [15:0] cl;
		int          base;
		int          low;
		int          dx;
		int          dy;
		cl = shape_cells(shape);

		// Height is one above the top filled visible cell
		for (int c = 0; c < `BOARD_COLS; c++) begin
			h[c] = 0;
			for (int r = 0; r < `VIS_ROWS; r++) begin
				if (grid[r][c])
					h[c] = r + 1;
			end
		end

		// Lowest bottom row where every cell sits at or above its column height
		base = 0;
		for (int k = 0; k < 4; k++) begin
			dx = cl[k*4+2 +: 2];
			dy = cl[k*4 +: 2];
			if (h[int'(col) + dx] - dy > base)
				base = h[int'(col) + dx] - dy;
		end
		for (int k = 0; k < 4; k++) begin
			dx = cl[k*4+2 +: 2];
			dy = cl[k*4 +: 2];
			grid[base + dy][int'(col) + dx] = 1'b1;
		end

		// Lowest full visible row goes first, all rows above drop by one
		do begin
			low = -1;
			for (int r = `VIS_ROWS - 1; r >= 0; r--) begin
				if (&grid[r])
					low = r;
			end
			if (low >= 0) begin
				for (int r = low; r < `ALL_ROWS - 1; r++)
					grid[r] = grid[r + 1];
				grid[`ALL_ROWS-1] = '0;
				score++;
			end
		end while (low >= 0);

		pieces++;
		exp_fail = 1'b0;
		for (int r = `VIS_ROWS; r < `ALL_ROWS; r++) begin
			if (|grid[r])
				exp_fail = 1'b1;  // Cell left in an overflow row
		end
		exp_end   = exp_fail || (pieces == `ROUND_PIECES);
		exp_score = score;
		for (int r = 0; r < `VIS_ROWS; r++)
			exp_board[r*`BOARD_COLS +: `BOARD_COLS] = grid[r];
		if (exp_end)
			clear_board();  // Next round starts empty
	endtask

	initial clear_board();

endmodule

// ==== test/tb_tetris_engine.sv ====
`timescale 1ns/1ps
`include "tetris_consts.svh"

module tb_tetris_engine;

	localparam int N_ENT   = 4;
	localparam int N_RAND  = 8;
	localparam int TIMEOUT = 64;
	localparam int FLAT_W  = `VIS_ROWS * `BOARD_COLS;

	// --------------------------------------------------
	// Stimulus table with pieces in octal as {shape, col}
	// --------------------------------------------------
	localparam logic [5:0] SEQ [N_ENT][16] = '{
		// Vertical I stacks in columns 0 to 4 and a last one that fills four rows
		'{6'o10, 6'o11, 6'o12, 6'o13, 6'o14, 6'o10, 6'o11, 6'o12,
		  6'o13, 6'o14, 6'o10, 6'o11, 6'o12, 6'o13, 6'o14, 6'o15},
		// Single row removals and then two rows at once
		'{6'o20, 6'o04, 6'o20, 6'o20, 6'o20, 6'o04, 6'o20, 6'o20,
		  6'o04, 6'o20, 6'o20, 6'o04, 6'o20, 6'o20, 6'o04, 6'o20},
		// Fourth vertical I in column 2 reaches row 12
		'{6'o12, 6'o12, 6'o12, 6'o12, 6'o00, 6'o00, 6'o00, 6'o00,
		  6'o00, 6'o00, 6'o00, 6'o00, 6'o00, 6'o00, 6'o00, 6'o00},
		// After the restart the O must land on the floor of a cleared column 2
		'{6'o01, 6'o11, 6'o11, 6'o11, 6'o00, 6'o00, 6'o00, 6'o00,
		  6'o00, 6'o00, 6'o00, 6'o00, 6'o00, 6'o00, 6'o00, 6'o00}
	};
	localparam int   END_IDX   [N_ENT] = '{15, 15, 3, 3};
	localparam int   EXP_SCORE [N_ENT] = '{4, 10, 0, 0};
	localparam logic EXP_FAIL  [N_ENT] = '{1'b0, 1'b0, 1'b1, 1'b1};

	logic                   clk;
	logic                   rst_n;
	logic                   in_valid_i;
	tetris_pkg::piece_req_t piece_i;
	logic                   score_valid_o;
	logic                   fail_o;
	logic                   tetris_valid_o;
	logic [`SCORE_W-1:0]    score_o;
	logic [FLAT_W-1:0]      tetris_o;

	integer seed      = 50421;
	int     errors    = 0;
	int     tests     = 0;
	int     clean     = 0;
	logic   timed_out = 1'b0;
	logic [`SCORE_W-1:0] last_score;
	logic                last_fail;

	tetris_engine dut (
		.clk            (clk),
		.rst_n          (rst_n),
		.in_valid_i     (in_valid_i),
		.piece_i        (piece_i),
		.score_valid_o  (score_valid_o),
		.fail_o         (fail_o),
		.tetris_valid_o (tetris_valid_o),
		.score_o        (score_o),
		.tetris_o       (tetris_o)
	);

	tb_board_model model ();

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic compare_value(input string name, input logic [FLAT_W-1:0] got,
			input logic [FLAT_W-1:0] exp);
		assert (got === exp) else begin
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	// One piece through the DUT and checked against the model
	task automatic play_piece(input logic [5:0] p, output logic ended);
		int   cyc;
		logic seen;
		model.apply_piece(p[5:3], p[2:0]);
		@(posedge clk);
		#1;
		piece_i    = tetris_pkg::piece_req_t'(p);
		in_valid_i = 1'b1;
		@(posedge clk);
		#1;
		in_valid_i = 1'b0;
		seen = 1'b0;
		cyc  = 0;
		while (!seen && cyc < TIMEOUT) begin
			@(negedge clk);
			if (score_valid_o) begin
				seen = 1'b1;
			end else begin
				compare_value("score_o", score_o, '0);  // Quiet between pulses
				compare_value("fail_o", fail_o, '0);
				compare_value("tetris_valid_o", tetris_valid_o, '0);
				compare_value("tetris_o", tetris_o, '0);
			end
			cyc++;
		end
		if (!seen) begin
			$display("Timeout: score_valid_o did not rise within %0d cycles", TIMEOUT);
			timed_out = 1'b1;
			errors++;
			ended = 1'b1;
		end else begin
			compare_value("score_o", score_o, model.exp_score);
			compare_value("fail_o", fail_o, model.exp_fail);
			compare_value("tetris_valid_o", tetris_valid_o, model.exp_end);
			compare_value("tetris_o", tetris_o, model.exp_end ? model.exp_board : '0);
			last_score = score_o;
			last_fail  = fail_o;
			ended      = tetris_valid_o;
		end
	endtask

	task automatic report_round(input string kind, input int idx, input int pieces,
			input int err0);
		tests++;
		if (errors == err0) begin
			clean++;
			$display("%s round %0d: %0d pieces, ok", kind, idx, pieces);
		end else begin
			$display("%s round %0d: %0d pieces, %0d mismatches", kind, idx, pieces,
				errors - err0);
		end
	endtask

	// --------------------------------------------------
	// Main sequence
	// --------------------------------------------------
	initial begin
		int         last_idx;
		int         start_err;
		int         col;
		logic       ended;
		logic [2:0] shape;
		rst_n      = 1'b0;
		in_valid_i = 1'b0;
		piece_i    = '0;
		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;

		for (int e = 0; e < N_ENT; e++) begin
			if (!timed_out) begin
				start_err = errors;
				ended     = 1'b0;
				last_idx  = 0;
				for (int i = 0; i < 16 && !ended; i++) begin
					play_piece(SEQ[e][i], ended);
					last_idx = i;
				end
				compare_value("round end piece", last_idx, END_IDX[e]);
				compare_value("score_o", last_score, EXP_SCORE[e]);
				compare_value("fail_o", last_fail, EXP_FAIL[e]);
				report_round("table", e, last_idx + 1, start_err);
			end
		end

		for (int r = 0; r < N_RAND; r++) begin
			if (!timed_out) begin
				start_err = errors;
				ended     = 1'b0;
				last_idx  = 0;
				for (int i = 0; i < 16 && !ended; i++) begin
					// Round r opens with shape r so every code is used
					shape = (i == 0) ? 3'(r) : 3'($unsigned($random(seed)) % 8);
					col   = $unsigned($random(seed)) %
						(`BOARD_COLS + 1 - model.piece_width(shape));
					play_piece({shape, 3'(col)}, ended);
					last_idx = i;
				end
				report_round("random", r, last_idx + 1, start_err);
			end
		end

		$display("%0d rounds, %0d clean, %0d errors", tests, clean, errors);
		if (errors == 0 && !timed_out)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== tetris_engine.f ====
+incdir+include
hw/tetris_pkg.sv
hw/drop_planner.sv
hw/board_store.sv
hw/round_ctrl.sv
hw/tetris_engine.sv
test/tb_board_model.sv
test/tb_tetris_engine.sv
